/* lsu.f */
source/lsu_pkg.sv
source/lsu_access_decode.sv
source/lsu_bus_arbiter.sv
source/lsu_load_align.sv
source/lsu_top.sv
test/lsu_arbiter_sva.sv
test/lsu_checker.sv
test/lsu_tb.sv

/* Makefile */
# Verilator build and run of the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= lsu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* test/lsu_tb.sv */
// testbench top of the load/store unit
// clock, reset, seeded random cpu accesses, bus responder
// dut and checker instances, closing summary

`timescale 1ns/1ns

module lsu_tb;

    localparam int n_access_c = 300; // accesses per run
    localparam int timeout_c  = 50;  // cycle limit per wait

    logic                 clk_i;
    logic                 rstn_i;
    lsu_pkg::lsu_ctrl_t   ctrl;
    lsu_pkg::addr_t       addr;
    lsu_pkg::word_t       wdata;
    lsu_pkg::dbus_rsp_t   dbus_rsp;
    lsu_pkg::dbus_req_t   dbus_req;
    lsu_pkg::word_t       rdata;
    lsu_pkg::addr_t       mar;
    lsu_pkg::lsu_status_t status;
    int                   n_err;            // from checker
    int                   n_done;           // from checker
    int                   n_sva;            // from bound assertions
    logic                 timed_out = 1'b0; // a wait ran out

    always #10 clk_i = ~clk_i; // 20 ns period

    lsu_top lsu_top_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .ctrl_i   (ctrl),
        .addr_i   (addr),
        .wdata_i  (wdata),
        .dbus_i   (dbus_rsp),
        .dbus_o   (dbus_req),
        .rdata_o  (rdata),
        .mar_o    (mar),
        .status_o (status)
    );

    lsu_checker lsu_checker_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .ctrl_i     (ctrl),
        .addr_i     (addr),
        .wdata_i    (wdata),
        .rsp_i      (dbus_rsp),
        .req_i      (dbus_req),
        .rdata_i    (rdata),
        .mar_i      (mar),
        .status_i   (status),
        .errors_o   (n_err),
        .accesses_o (n_done)
    );

    assign n_sva = lsu_top_inst.lsu_bus_arbiter_inst.lsu_arbiter_sva_inst.n_fail;

    // bus enable started, or error flag raised
    function automatic logic event_seen(input logic want_flag);
        if (want_flag) begin
            return status.ma_load | status.ma_store | status.be_load | status.be_store;
        end
        return dbus_req.we | dbus_req.re | status.ma_load | status.ma_store;
    endfunction

    task automatic wait_for_event(input logic want_flag, input string what);
        int cnt;
        cnt = 0;
        @(negedge clk_i);
        while (!event_seen(want_flag) && cnt < timeout_c) begin
            @(negedge clk_i);
            cnt++;
        end
        if (!event_seen(want_flag)) begin
            $display("timeout: no %s within %0d cycles on access %0d", what, timeout_c, n_done);
            timed_out = 1'b1;
        end
    endtask

    // ----------------------------------------------------------------------
    // one random access: strobe, request, bus answer or trap
    // ----------------------------------------------------------------------
    task automatic run_access();
        int   lat;
        logic bad_bus;
        @(posedge clk_i);
        #1;
        ctrl.addr_we     = 1'b1;
        ctrl.is_store    = ($urandom_range(0, 1) == 1);
        ctrl.size        = lsu_pkg::mem_size_t'(2'($urandom_range(0, 2)));
        ctrl.is_unsigned = ($urandom_range(0, 1) == 1);
        addr             = $urandom;
        wdata            = $urandom;
        if ($urandom_range(0, 3) != 0) begin                 // mostly aligned
            if (ctrl.size == lsu_pkg::size_word_c) addr[1:0] = 2'b00;
            if (ctrl.size == lsu_pkg::size_half_c) addr[0] = 1'b0;
        end
        @(posedge clk_i);
        #1;
        ctrl.addr_we = 1'b0;
        ctrl.bus_req = 1'b1;
        wait_for_event(1'b0, "bus enable or misaligned flag");
        if (timed_out) return;
        if (dbus_req.we || dbus_req.re) begin
            lat = $urandom_range(1, 4);                       // slow bus
            repeat (lat) @(posedge clk_i);
            #1;
            bad_bus        = ($urandom_range(0, 9) == 0);
            dbus_rsp.rdata = $urandom;
            dbus_rsp.ack   = ~bad_bus;
            dbus_rsp.err   = bad_bus;
            @(posedge clk_i);
            #1;
            dbus_rsp.ack = 1'b0;
            dbus_rsp.err = 1'b0;
            if (!bad_bus) begin
                ctrl.bus_req = 1'b0;                          // normal end
                return;
            end
        end
        wait_for_event(1'b1, "error flag");
        if (timed_out) return;
        @(posedge clk_i);
        #1;
        ctrl.cpu_trap = 1'b1;                                 // cpu takes the trap
        @(posedge clk_i);
        #1;
        ctrl.cpu_trap = 1'b0;
        ctrl.bus_req  = 1'b0;
    endtask

    initial begin : main
        clk_i    = 1'b0;
        rstn_i   = 1'b0;
        ctrl     = '0;
        addr     = '0;
        wdata    = '0;
        dbus_rsp = '0;
        void'($urandom(32'h5253));
        repeat (16) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        for (int i = 0; i < n_access_c; i++) begin
            run_access();
            if (timed_out) break;
        end
        repeat (2) @(negedge clk_i); // last rdata compare and report
        $display("done: %0d accesses, %0d errors, %0d assertion failures",
                 n_done, n_err, n_sva);
        if (!timed_out && n_err == 0 && n_sva == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end : main

endmodule

/* test/lsu_checker.sv */
// reference model and checker of the load/store unit
// predicts latched address, lanes, enables, status and load data
// one line per finished access, error and access counts out

`timescale 1ns/1ns

module lsu_checker (
    input  logic                 clk_i,      // dut clock
    input  logic                 rstn_i,     // dut reset
    input  lsu_pkg::lsu_ctrl_t   ctrl_i,     // cpu control to the dut
    input  lsu_pkg::addr_t       addr_i,     // access address to the dut
    input  lsu_pkg::word_t       wdata_i,    // store data to the dut
    input  lsu_pkg::dbus_rsp_t   rsp_i,      // bus response to the dut
    input  lsu_pkg::dbus_req_t   req_i,      // bus request from the dut
    input  lsu_pkg::word_t       rdata_i,    // load result from the dut
    input  lsu_pkg::addr_t       mar_i,      // address register from the dut
    input  lsu_pkg::lsu_status_t status_i,   // flags from the dut
    output int                   errors_o,   // mismatches so far
    output int                   accesses_o  // finished accesses
);

    lsu_pkg::addr_t       exp_addr  = '0;   // predicted mar
    lsu_pkg::ben_t        exp_ben   = '0;   // predicted enables
    lsu_pkg::word_t       exp_wdata = '0;   // predicted write lanes
    lsu_pkg::word_t       exp_rdata = '0;   // predicted load result
    lsu_pkg::lsu_status_t exp_st;           // predicted flags
    logic                 exp_mis   = 1'b0; // predicted alignment fault
    logic                 m_pend    = 1'b0; // model arbiter state
    logic                 m_err     = 1'b0; // model collected error
    logic                 chk_latch = 1'b0; // compare latch next cycle
    logic                 chk_load  = 1'b0; // compare rdata next cycle
    logic                 close_acc = 1'b0; // report access next cycle
    int                   n_err     = 0;
    int                   n_acc     = 0;
    int                   acc_errs  = 0;    // errors in current access

    assign errors_o   = n_err;
    assign accesses_o = n_acc;

    function automatic lsu_pkg::ben_t lane_mask(lsu_pkg::mem_size_t sz, logic [1:0] off);
        case (sz)
            lsu_pkg::size_byte_c: return 4'b0001 << off;            // one lane
            lsu_pkg::size_half_c: return 4'b0011 << {off[1], 1'b0}; // lane pair
            default:              return 4'b1111;
        endcase
    endfunction

    function automatic lsu_pkg::word_t lane_data(lsu_pkg::mem_size_t sz, lsu_pkg::word_t d);
        case (sz)
            lsu_pkg::size_byte_c: return {4{d[7:0]}};
            lsu_pkg::size_half_c: return {2{d[15:0]}};
            default:              return d;
        endcase
    endfunction

    function automatic logic is_misaligned(lsu_pkg::mem_size_t sz, logic [1:0] off);
        case (sz)
            lsu_pkg::size_byte_c: return 1'b0;
            lsu_pkg::size_half_c: return off[0];
            default:              return off != 2'b00;
        endcase
    endfunction

    // shift the addressed lane down, then extend
    function automatic lsu_pkg::word_t load_value(lsu_pkg::mem_size_t sz, logic uns,
                                                  logic [1:0] off, lsu_pkg::word_t w);
        lsu_pkg::word_t s;
        s = w >> {off, 3'b000};
        case (sz)
            lsu_pkg::size_byte_c: return {{24{s[7] & ~uns}}, s[7:0]};
            lsu_pkg::size_half_c: return {{16{s[15] & ~uns}}, s[15:0]};
            default:              return w;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            n_err++;
            acc_errs++;
        end
    endtask

    // ----------------------------------------------------------------------
    // compare at falling edges, then step the model to the next rising edge
    // ----------------------------------------------------------------------
    always @(negedge clk_i) begin : model
        if (chk_latch) begin
            check("mar", mar_i, exp_addr);
            check("bus addr", req_i.addr, exp_addr);
            check("ben", {28'b0, req_i.ben}, {28'b0, exp_ben});
            check("wdata", req_i.wdata, exp_wdata);
            chk_latch = 1'b0;
        end
        if (chk_load) begin
            check("rdata", rdata_i, exp_rdata);
            chk_load = 1'b0;
        end
        if (close_acc) begin
            $display("access %0d: %s size %0d addr 0x%08h %s", n_acc,
                     ctrl_i.is_store ? "store" : "load", ctrl_i.size, mar_i,
                     acc_errs == 0 ? "ok" : "FAILED");
            n_acc++;
            acc_errs  = 0;
            close_acc = 1'b0;
        end
        exp_st.d_wait   = ~rsp_i.ack;
        exp_st.ma_load  = m_pend & ~ctrl_i.is_store & exp_mis;
        exp_st.ma_store = m_pend & ctrl_i.is_store & exp_mis;
        exp_st.be_load  = m_pend & ~ctrl_i.is_store & m_err;
        exp_st.be_store = m_pend & ctrl_i.is_store & m_err;
        check("status", {27'b0, status_i}, {27'b0, exp_st});
        check("we/re", {30'b0, req_i.we, req_i.re},
              {30'b0, ctrl_i.bus_req & ctrl_i.is_store & ~exp_mis,
               ctrl_i.bus_req & ~ctrl_i.is_store & ~exp_mis});
        if (rstn_i == 1'b0) begin
            m_pend = 1'b0;
            m_err  = 1'b0;
        end else if (m_pend == 1'b0) begin
            m_err  = 1'b0;            // new access starts clean
            m_pend = ctrl_i.bus_req;
        end else begin
            m_err = m_err | rsp_i.err;
            if (rsp_i.ack || ctrl_i.cpu_trap) begin
                m_pend    = 1'b0;
                close_acc = 1'b1;
                if (rsp_i.ack && !ctrl_i.is_store) begin
                    exp_rdata = load_value(ctrl_i.size, ctrl_i.is_unsigned,
                                           exp_addr[1:0], rsp_i.rdata);
                    chk_load  = 1'b1;
                end
            end
        end
        if (ctrl_i.addr_we == 1'b1) begin
            exp_addr  = addr_i;
            exp_ben   = lane_mask(ctrl_i.size, addr_i[1:0]);
            exp_wdata = lane_data(ctrl_i.size, wdata_i);
            exp_mis   = is_misaligned(ctrl_i.size, addr_i[1:0]);
            chk_latch = 1'b1;
        end
    end : model

endmodule

/* test/lsu_arbiter_sva.sv */
// concurrent assertions on the data bus arbiter
// enable exclusion, misaligned masking, status error flags
// attached to every lsu_bus_arbiter through bind

`timescale 1ns/1ns

module lsu_arbiter_sva (
    input logic                 clk_i,        // arbiter clock
    input logic                 rstn_i,       // arbiter reset
    input logic                 we_i,         // write enable out
    input logic                 re_i,         // read enable out
    input logic                 misaligned_i, // latched alignment fault
    input lsu_pkg::arb_state_t  state_i,      // fsm state
    input lsu_pkg::lsu_status_t status_i      // flags to the cpu
);

    int n_fail = 0; // failed assertions so far

    // one direction per access
    we_re_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(we_i && re_i))
        else begin
            n_fail++;
            $error("we and re high in the same cycle");
        end

    // misaligned address never reaches the bus
    ma_no_enable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        misaligned_i |-> !(we_i || re_i))
        else begin
            n_fail++;
            $error("bus enable high with misaligned address");
        end

    be_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(status_i.be_load && status_i.be_store))
        else begin
            n_fail++;
            $error("load and store bus error flags high together");
        end

    // error flags only while pending
    idle_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_i == lsu_pkg::arb_idle_c) |-> !(status_i.ma_load || status_i.ma_store
            || status_i.be_load || status_i.be_store))
        else begin
            n_fail++;
            $error("status error flag high while idle");
        end

endmodule

bind lsu_bus_arbiter lsu_arbiter_sva lsu_arbiter_sva_inst (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .we_i         (we_o),
    .re_i         (re_o),
    .misaligned_i (misaligned_i),
    .state_i      (state_q),
    .status_i     (status_o)
);

/* source/lsu_top.sv */
// top level of the load/store unit data side
// access decode, bus arbiter and load alignment
// packs the outgoing data bus request

`timescale 1ns/1ns

module lsu_top (
    input  logic                 clk_i,    // clock, rising edge
    input  logic                 rstn_i,   // async reset, active low
    input  lsu_pkg::lsu_ctrl_t   ctrl_i,   // cpu control
    input  lsu_pkg::addr_t       addr_i,   // access address
    input  lsu_pkg::word_t       wdata_i,  // store data
    input  lsu_pkg::dbus_rsp_t   dbus_i,   // bus response
    output lsu_pkg::dbus_req_t   dbus_o,   // bus request
    output lsu_pkg::word_t       rdata_o,  // load result
    output lsu_pkg::addr_t       mar_o,    // address register for mtval
    output lsu_pkg::lsu_status_t status_o  // flags to the cpu
);

    lsu_pkg::addr_t mar;        // latched address
    logic           misaligned; // latched alignment fault
    lsu_pkg::ben_t  ben;        // byte enables
    lsu_pkg::word_t wdata;      // write lanes
    logic           we;         // write enable
    logic           re;         // read enable

    // ---------------------------------------------------------------------
    // address, alignment and write lanes
    // ---------------------------------------------------------------------
    lsu_access_decode lsu_access_decode_inst (
        .clk_i        (clk_i),
        .ctrl_i       (ctrl_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .mar_o        (mar),
        .misaligned_o (misaligned),
        .ben_o        (ben),
        .wdata_o      (wdata)
    );

    // ---------------------------------------------------------------------
    // access arbiter
    // ---------------------------------------------------------------------
    lsu_bus_arbiter lsu_bus_arbiter_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .ctrl_i       (ctrl_i),
        .misaligned_i (misaligned),
        .ack_i        (dbus_i.ack),
        .err_i        (dbus_i.err),
        .we_o         (we),
        .re_o         (re),
        .status_o     (status_o)
    );

    // load data path
    lsu_load_align lsu_load_align_inst (
        .clk_i         (clk_i),
        .size_i        (ctrl_i.size),
        .is_unsigned_i (ctrl_i.is_unsigned),
        .addr_lsb_i    (mar[1:0]),
        .rdata_i       (dbus_i.rdata),
        .rdata_o       (rdata_o)
    );

    assign dbus_o.addr  = mar;
    assign dbus_o.wdata = wdata;
    assign dbus_o.ben   = ben;
    assign dbus_o.we    = we;
    assign dbus_o.re    = re;
    assign mar_o        = mar;

endmodule

/* source/lsu_load_align.sv */
// load data alignment
// byte and half-word lane select from the bus word
// sign or zero extension, registered every cycle

`timescale 1ns/1ns

module lsu_load_align (
    input  logic               clk_i,         // clock, rising edge
    input  lsu_pkg::mem_size_t size_i,        // access size
    input  logic               is_unsigned_i, // lbu / lhu
    input  logic [1:0]         addr_lsb_i,    // low address bits from mar
    input  lsu_pkg::word_t     rdata_i,       // bus read data
    output lsu_pkg::word_t     rdata_o        // aligned load result
);

    lsu_pkg::word_t rdata_q;   // result register
    lsu_pkg::word_t rdata_nxt; // aligned word
    logic [7:0]     byte_sel;  // selected byte
    logic [15:0]    half_sel;  // selected half-word
    logic           sign_b;    // byte extension bit
    logic           sign_h;    // half extension bit

    // ---------------------------------------------------------------------
    // lane select
    // ---------------------------------------------------------------------
    always_comb begin : lane_sel
        unique case (addr_lsb_i)
            2'b00:   byte_sel = rdata_i[7:0];
            2'b01:   byte_sel = rdata_i[15:8];
            2'b10:   byte_sel = rdata_i[23:16];
            default: byte_sel = rdata_i[31:24];
        endcase
        if (addr_lsb_i[1] == 1'b0) begin
            half_sel = rdata_i[15:0];  // low half
        end else begin
            half_sel = rdata_i[31:16]; // high half
        end
    end : lane_sel

    assign sign_b = ~is_unsigned_i & byte_sel[7];  // zero when unsigned
    assign sign_h = ~is_unsigned_i & half_sel[15];

    // ---------------------------------------------------------------------
    // extension by size
    // ---------------------------------------------------------------------
    always_comb begin : extend
        unique case (size_i)
            lsu_pkg::size_byte_c: rdata_nxt = {{24{sign_b}}, byte_sel};
            lsu_pkg::size_half_c: rdata_nxt = {{16{sign_h}}, half_sel};
            default:              rdata_nxt = rdata_i; // word passes through
        endcase
    end : extend

    always_ff @(posedge clk_i) begin : load_reg
        rdata_q <= rdata_nxt; // valid the cycle after ack
    end : load_reg

    assign rdata_o = rdata_q;

endmodule

/* source/lsu_bus_arbiter.sv */
// single-access data bus arbiter
// idle/pending fsm with bus error collection
// read/write enables and status flags to the cpu

`timescale 1ns/1ns

module lsu_bus_arbiter (
    input  logic                 clk_i,        // clock, rising edge
    input  logic                 rstn_i,       // async reset, active low
    input  lsu_pkg::lsu_ctrl_t   ctrl_i,       // cpu control
    input  logic                 misaligned_i, // latched alignment fault
    input  logic                 ack_i,        // bus acknowledge
    input  logic                 err_i,        // bus error pulse
    output logic                 we_o,         // bus write enable
    output logic                 re_o,         // bus read enable
    output lsu_pkg::lsu_status_t status_o      // flags to the cpu
);

    lsu_pkg::arb_state_t state_q; // fsm state
    logic                err_q;   // collected bus error
    logic                pend;    // access in flight

    // ---------------------------------------------------------------------
    // fsm and error accumulation
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin : arb_fsm
        if (rstn_i == 1'b0) begin
            state_q <= lsu_pkg::arb_idle_c;
            err_q   <= 1'b0;
        end else begin
            unique case (state_q)
                lsu_pkg::arb_idle_c: begin
                    err_q <= 1'b0;                       // fresh access, no error
                    if (ctrl_i.bus_req == 1'b1) begin
                        state_q <= lsu_pkg::arb_pend_c;  // start access
                    end
                end
                default: begin
                    if (err_i == 1'b1) begin
                        err_q <= 1'b1;                   // sticky until idle
                    end
                    // normal end or trap entry
                    if ((ack_i == 1'b1) || (ctrl_i.cpu_trap == 1'b1)) begin
                        state_q <= lsu_pkg::arb_idle_c;
                    end
                end
            endcase
        end
    end : arb_fsm

    assign pend = (state_q == lsu_pkg::arb_pend_c);

    // bus enables, killed on misaligned address
    assign we_o = ctrl_i.bus_req &  ctrl_i.is_store & ~misaligned_i;
    assign re_o = ctrl_i.bus_req & ~ctrl_i.is_store & ~misaligned_i;

    // ---------------------------------------------------------------------
    // status flags, only while pending
    // ---------------------------------------------------------------------
    always_comb begin : arb_status
        status_o.d_wait   = ~ack_i;                                   // stall until ack
        status_o.ma_load  = pend & ~ctrl_i.is_store & misaligned_i;
        status_o.ma_store = pend &  ctrl_i.is_store & misaligned_i;
        status_o.be_load  = pend & ~ctrl_i.is_store & err_q;
        status_o.be_store = pend &  ctrl_i.is_store & err_q;
    end : arb_status

endmodule

/* source/lsu_access_decode.sv */
// access decode of the load/store unit
// memory address register and alignment check
// byte enables and write data lane placement

`timescale 1ns/1ns

module lsu_access_decode (
    input  logic              clk_i,        // clock, rising edge
    input  lsu_pkg::lsu_ctrl_t ctrl_i,      // cpu control
    input  lsu_pkg::addr_t    addr_i,       // alu result, access address
    input  lsu_pkg::word_t    wdata_i,      // store data from rs2
    output lsu_pkg::addr_t    mar_o,        // memory address register
    output logic              misaligned_o, // latched alignment fault
    output lsu_pkg::ben_t     ben_o,        // latched byte enables
    output lsu_pkg::word_t    wdata_o       // latched write lanes
);

    lsu_pkg::addr_t mar_q;          // address register
    logic           misaligned_q;   // alignment fault register
    lsu_pkg::ben_t  ben_q;          // byte enable register
    lsu_pkg::word_t wdata_q;        // write lane register

    logic           misaligned_nxt; // alignment check result
    lsu_pkg::ben_t  ben_nxt;        // decoded enables
    lsu_pkg::word_t wdata_nxt;      // replicated store data

    // ---------------------------------------------------------------------
    // alignment, lanes and enables from size and offset
    // ---------------------------------------------------------------------
    always_comb begin : decode_comb
        misaligned_nxt = 1'b0;
        ben_nxt        = '0;
        wdata_nxt      = wdata_i;  // word default
        unique case (ctrl_i.size)
            lsu_pkg::size_byte_c: begin
                misaligned_nxt       = 1'b0;              // bytes always aligned
                wdata_nxt            = {4{wdata_i[7:0]}}; // byte on every lane
                ben_nxt[addr_i[1:0]] = 1'b1;              // single lane
            end
            lsu_pkg::size_half_c: begin
                misaligned_nxt = addr_i[0];            // needs even address
                wdata_nxt      = {2{wdata_i[15:0]}};   // half on both halves
                if (addr_i[1] == 1'b0) begin
                    ben_nxt = 4'b0011;                 // low half
                end else begin
                    ben_nxt = 4'b1100;                 // high half
                end
            end
            default: begin
                misaligned_nxt = addr_i[1] | addr_i[0]; // needs word boundary
                wdata_nxt      = wdata_i;               // full word
                ben_nxt        = '1;                    // all lanes
            end
        endcase
    end : decode_comb

    // ---------------------------------------------------------------------
    // registers, loaded on the address strobe
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i) begin : decode_reg
        if (ctrl_i.addr_we == 1'b1) begin
            mar_q        <= addr_i;         // also feeds mtval
            misaligned_q <= misaligned_nxt;
            ben_q        <= ben_nxt;
            wdata_q      <= wdata_nxt;
        end
    end : decode_reg

    assign mar_o        = mar_q;
    assign misaligned_o = misaligned_q;
    assign ben_o        = ben_q;
    assign wdata_o      = wdata_q;

endmodule

/* source/lsu_pkg.sv */
// shared definitions of the load/store unit
// width constants, vector types, size and arbiter enums
// packed structs of cpu control, data bus and status flags

package lsu_pkg;

    // ---------------------------------------------------------------------
    // widths
    // ---------------------------------------------------------------------
    localparam int xlen_c   = 32;       // data path width
    localparam int nbytes_c = xlen_c/8; // byte lanes per word

    typedef logic [xlen_c-1:0]   word_t; // one data word
    typedef logic [xlen_c-1:0]   addr_t; // byte address
    typedef logic [nbytes_c-1:0] ben_t;  // one bit per byte lane

    // ---------------------------------------------------------------------
    // enums
    // ---------------------------------------------------------------------
    typedef enum logic [1:0] {
        size_byte_c = 2'b00, // lb / lbu / sb
        size_half_c = 2'b01, // lh / lhu / sh
        size_word_c = 2'b10  // lw / sw
    } mem_size_t;            // funct3[1:0]

    typedef enum logic {
        arb_idle_c = 1'b0, // no access in flight
        arb_pend_c = 1'b1  // waiting for ack or trap
    } arb_state_t;

    // ---------------------------------------------------------------------
    // structs
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic      addr_we;     // latch address, one-cycle strobe
        mem_size_t size;        // access size
        logic      is_unsigned; // funct3[2], zero-extend loads
        logic      is_store;    // opcode[5]
        logic      bus_req;     // request level, held during access
        logic      cpu_trap;    // trap entry, ends access
    } lsu_ctrl_t;

    typedef struct packed {
        addr_t addr;  // access address
        word_t wdata; // write data, lanes replicated
        ben_t  ben;   // byte enables
        logic  we;    // write enable
        logic  re;    // read enable
    } dbus_req_t;

    typedef struct packed {
        word_t rdata; // read data
        logic  ack;   // transfer done
        logic  err;   // transfer error, no ack
    } dbus_rsp_t;

    typedef struct packed {
        logic d_wait;   // access not yet acknowledged (wait is a keyword)
        logic ma_load;  // misaligned load
        logic ma_store; // misaligned store
        logic be_load;  // bus error on load
        logic be_store; // bus error on store
    } lsu_status_t;

endpackage
